//--- logic/cr_pkg.sv
`default_nettype none

package cr_pkg;

    // ==================================================
    // Sizes
    // ==================================================
    localparam int CR_DATA_W     = 32;
    localparam int CR_ADDR_W     = 8;
    localparam int NUM_THREADS   = 4;
    localparam int THREAD_IDX_W  = 2;
    localparam int CORE_ID_W     = 8;
    localparam int NUM_SCRATCH   = 4;
    localparam int SCRATCH_IDX_W = 2;
    localparam int CR_KIND_W     = 3;
    localparam int CR_TAG_W      = CR_ADDR_W - CR_KIND_W - THREAD_IDX_W;

    localparam int NUM_PORTS     = 2;
    localparam int PORT_CORE     = 0;
    localparam int PORT_RING     = 1;   // Wins when both ports write one register

    // ==================================================
    // Global register addresses
    // ==================================================
    localparam logic [CR_ADDR_W-1:0] CR_WHO_AM_I           = 8'h00;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD_ID          = 8'h01;
    localparam logic [CR_ADDR_W-1:0] CR_CORE_ID            = 8'h02;
    localparam logic [CR_ADDR_W-1:0] CR_STACK_BASE_OFFSET  = 8'h03;  // Current thread view
    localparam logic [CR_ADDR_W-1:0] CR_TLS_BASE_OFFSET    = 8'h04;  // Current thread view
    localparam logic [CR_ADDR_W-1:0] CR_SHARED_BASE_OFFSET = 8'h05;
    localparam logic [CR_ADDR_W-1:0] CR_SCRATCHPAD_BASE    = 8'h10;  // Four words, aligned

    // ==================================================
    // Per-thread register space
    // ==================================================
    localparam logic [CR_TAG_W-1:0]  PER_THREAD_TAG = 3'b100;        // 0x80..0x9f

    localparam logic [CR_KIND_W-1:0] KIND_PC_RST    = 3'd0;
    localparam logic [CR_KIND_W-1:0] KIND_PC_EN     = 3'd1;
    localparam logic [CR_KIND_W-1:0] KIND_STK_OFST  = 3'd2;
    localparam logic [CR_KIND_W-1:0] KIND_TLS_OFST  = 3'd3;
    localparam logic [CR_KIND_W-1:0] KIND_PC        = 3'd4;          // Read only

    // Default stack offsets, thread 3 down to thread 0
    localparam logic [NUM_THREADS-1:0][CR_DATA_W-1:0] STK_OFFSET_RST = {
        32'h0000_4000,
        32'h0000_3000,
        32'h0000_2000,
        32'h0000_1000
    };

    localparam logic [CR_DATA_W-1:0] SHARED_OFFSET_RST = 32'h0000_8000;

    // Raw view for global registers, field view for per-thread ones
    typedef union packed {
        logic [CR_ADDR_W-1:0] raw;
        struct packed {
            logic [CR_TAG_W-1:0]     tag;
            logic [CR_KIND_W-1:0]    kind;
            logic [THREAD_IDX_W-1:0] tidx;
        } pt;
    } cr_addr_u;

endpackage

`default_nettype wire

//--- logic/cr_access_if.sv
`timescale 1ns/1ps
`default_nettype none

// One register access port, no handshake
interface cr_access_if
    import cr_pkg::*;
();

    cr_addr_u             addr;
    logic [CR_DATA_W-1:0] wr_data;
    logic                 wr_en;     // Accepted at every rising edge it is high
    logic                 rd_en;     // Data returns one cycle later

    modport writer_side (
        input addr,
        input wr_data,
        input wr_en
    );

    modport reader_side (
        input addr,
        input rd_en
    );

endinterface

`default_nettype wire

//--- logic/cr_rw_if.sv
`timescale 1ns/1ps
`default_nettype none

// Software-writable register state
interface cr_rw_if
    import cr_pkg::*;
();

    logic [NUM_THREADS-1:0]                rst_pc;     // Before the all-PC-reset OR
    logic [NUM_THREADS-1:0]                en_pc;
    logic [NUM_THREADS-1:0][CR_DATA_W-1:0] stk_ofst;
    logic [NUM_THREADS-1:0][CR_DATA_W-1:0] tls_ofst;
    logic [NUM_SCRATCH-1:0][CR_DATA_W-1:0] scratch;
    logic [CR_DATA_W-1:0]                  shrd_ofst;

    modport driver (
        output rst_pc,
        output en_pc,
        output stk_ofst,
        output tls_ofst,
        output scratch,
        output shrd_ofst
    );

    modport reader (
        input rst_pc,
        input en_pc,
        input stk_ofst,
        input tls_ofst,
        input scratch,
        input shrd_ofst
    );

endinterface

`default_nettype wire

//--- logic/cr_ro_if.sv
`timescale 1ns/1ps
`default_nettype none

// Hardware-sampled read-only state
interface cr_ro_if
    import cr_pkg::*;
();

    logic [THREAD_IDX_W-1:0]               thread_id;
    logic [CR_DATA_W-1:0]                  cur_stk_ofst;
    logic [CR_DATA_W-1:0]                  cur_tls_ofst;
    logic [NUM_THREADS-1:0][CR_DATA_W-1:0] pc;            // Last PC seen per thread
    logic [CORE_ID_W-1:0]                  core_id;

    modport driver (
        output thread_id,
        output cur_stk_ofst,
        output cur_tls_ofst,
        output pc,
        output core_id
    );

    modport reader (
        input thread_id,
        input cur_stk_ofst,
        input cur_tls_ofst,
        input pc,
        input core_id
    );

endinterface

`default_nettype wire

//--- logic/cr_rw_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cr_rw_regs
    import cr_pkg::*;
(
    input  logic              qclk,
    input  logic              rst_n,
    cr_access_if.writer_side  core_port,
    cr_access_if.writer_side  ring_port,
    cr_rw_if.driver           rw
);

    cr_addr_u               wr_addr [NUM_PORTS];
    logic [NUM_PORTS-1:0]   wr_en;
    logic [CR_DATA_W-1:0]   core_data;
    logic [CR_DATA_W-1:0]   ring_data;

    // Per-port write enables, one bit per register
    logic [NUM_THREADS-1:0] rst_pc_we  [NUM_PORTS];
    logic [NUM_THREADS-1:0] en_pc_we   [NUM_PORTS];
    logic [NUM_THREADS-1:0] stk_we     [NUM_PORTS];
    logic [NUM_THREADS-1:0] tls_we     [NUM_PORTS];
    logic [NUM_SCRATCH-1:0] scratch_we [NUM_PORTS];
    logic [NUM_PORTS-1:0]   shrd_we;

    assign wr_addr[PORT_CORE] = core_port.addr;
    assign wr_addr[PORT_RING] = ring_port.addr;
    assign wr_en[PORT_CORE]   = core_port.wr_en;
    assign wr_en[PORT_RING]   = ring_port.wr_en;
    assign core_data          = core_port.wr_data;
    assign ring_data          = ring_port.wr_data;

    // ==================================================
    // Write decode, same logic for both ports
    // ==================================================
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            rst_pc_we[p]  = '0;
            en_pc_we[p]   = '0;
            stk_we[p]     = '0;
            tls_we[p]     = '0;
            scratch_we[p] = '0;
            shrd_we[p]    = 1'b0;
            if (wr_en[p]) begin
                if (wr_addr[p].pt.tag == PER_THREAD_TAG) begin
                    case (wr_addr[p].pt.kind)
                        KIND_PC_RST   : rst_pc_we[p][wr_addr[p].pt.tidx] = 1'b1;
                        KIND_PC_EN    : en_pc_we[p][wr_addr[p].pt.tidx]  = 1'b1;
                        KIND_STK_OFST : stk_we[p][wr_addr[p].pt.tidx]    = 1'b1;
                        KIND_TLS_OFST : tls_we[p][wr_addr[p].pt.tidx]    = 1'b1;
                        default       : ;                  // PC and unused kinds ignore writes
                    endcase
                end else if (wr_addr[p].raw == CR_SHARED_BASE_OFFSET) begin
                    shrd_we[p] = 1'b1;
                end else if (wr_addr[p].raw[CR_ADDR_W-1:SCRATCH_IDX_W] ==
                             CR_SCRATCHPAD_BASE[CR_ADDR_W-1:SCRATCH_IDX_W]) begin
                    scratch_we[p][wr_addr[p].raw[SCRATCH_IDX_W-1:0]] = 1'b1;
                end
            end
        end
    end

    // ==================================================
    // Register flops, ring data taken on its enable
    // ==================================================
    always_ff @(posedge qclk or negedge rst_n) begin
        if (!rst_n) begin
            rw.rst_pc    <= '0;
            rw.en_pc     <= '1;                            // Threads run out of reset
            rw.stk_ofst  <= STK_OFFSET_RST;
            rw.tls_ofst  <= STK_OFFSET_RST;                // Same default as the stack
            rw.scratch   <= '0;
            rw.shrd_ofst <= SHARED_OFFSET_RST;
        end else begin
            for (int t = 0; t < NUM_THREADS; t++) begin
                if (rst_pc_we[PORT_CORE][t] || rst_pc_we[PORT_RING][t]) begin
                    rw.rst_pc[t] <= rst_pc_we[PORT_RING][t] ? ring_data[0] : core_data[0];
                end
                if (en_pc_we[PORT_CORE][t] || en_pc_we[PORT_RING][t]) begin
                    rw.en_pc[t] <= en_pc_we[PORT_RING][t] ? ring_data[0] : core_data[0];
                end
                if (stk_we[PORT_CORE][t] || stk_we[PORT_RING][t]) begin
                    rw.stk_ofst[t] <= stk_we[PORT_RING][t] ? ring_data : core_data;
                end
                if (tls_we[PORT_CORE][t] || tls_we[PORT_RING][t]) begin
                    rw.tls_ofst[t] <= tls_we[PORT_RING][t] ? ring_data : core_data;
                end
            end
            for (int s = 0; s < NUM_SCRATCH; s++) begin
                if (scratch_we[PORT_CORE][s] || scratch_we[PORT_RING][s]) begin
                    rw.scratch[s] <= scratch_we[PORT_RING][s] ? ring_data : core_data;
                end
            end
            if (shrd_we[PORT_CORE] || shrd_we[PORT_RING]) begin
                rw.shrd_ofst <= shrd_we[PORT_RING] ? ring_data : core_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/cr_thread_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module cr_thread_sampler
    import cr_pkg::*;
(
    input  logic                   qclk,
    input  logic                   rst_n,
    input  logic [NUM_THREADS-1:0] thread,     // One-hot, running thread
    input  logic [CR_DATA_W-1:0]   pc,
    input  logic [CORE_ID_W-1:0]   core_id,    // Static strap
    cr_rw_if.reader                rw,
    cr_ro_if.driver                ro
);

    logic [NUM_THREADS-1:0]  thread_prev;
    logic [THREAD_IDX_W-1:0] thread_idx;

    // Thread one pipe stage earlier, so one-hot bit 3 becomes index 0
    assign thread_prev = {thread[NUM_THREADS-2:0], thread[NUM_THREADS-1]};

    always_comb begin
        thread_idx = '0;
        for (int t = 0; t < NUM_THREADS; t++) begin
            if (thread_prev[t]) begin
                thread_idx = THREAD_IDX_W'(t);
            end
        end
    end

    // ==================================================
    // Sampled every cycle
    // ==================================================
    always_ff @(posedge qclk or negedge rst_n) begin
        if (!rst_n) begin
            ro.thread_id    <= '0;
            ro.cur_stk_ofst <= '0;
            ro.cur_tls_ofst <= '0;
            ro.pc           <= '0;
            ro.core_id      <= '0;
        end else begin
            ro.thread_id          <= thread_idx;
            ro.cur_stk_ofst       <= rw.stk_ofst[thread_idx];
            ro.cur_tls_ofst       <= rw.tls_ofst[thread_idx];
            ro.pc[thread_idx]     <= pc;           // Other threads keep their last PC
            ro.core_id            <= core_id;      // Strap copy
        end
    end

endmodule

`default_nettype wire

//--- logic/cr_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module cr_read_mux
    import cr_pkg::*;
(
    input  logic                 qclk,
    input  logic                 rst_n,
    cr_access_if.reader_side     core_port,
    cr_access_if.reader_side     ring_port,
    cr_rw_if.reader              rw,
    cr_ro_if.reader              ro,
    output logic [CR_DATA_W-1:0] core_rd_data,
    output logic [CR_DATA_W-1:0] ring_rd_data
);

    cr_addr_u             rd_addr [NUM_PORTS];
    logic [NUM_PORTS-1:0] rd_en;
    logic [CR_DATA_W-1:0] rd_next [NUM_PORTS];

    assign rd_addr[PORT_CORE] = core_port.addr;
    assign rd_addr[PORT_RING] = ring_port.addr;
    assign rd_en[PORT_CORE]   = core_port.rd_en;
    assign rd_en[PORT_RING]   = ring_port.rd_en;

    // ==================================================
    // Read decode, same logic for both ports
    // ==================================================
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            rd_next[p] = '0;                       // Idle cycle or unknown address
            if (rd_en[p]) begin
                if (rd_addr[p].pt.tag == PER_THREAD_TAG) begin
                    case (rd_addr[p].pt.kind)
                        KIND_PC_RST   : rd_next[p] = CR_DATA_W'(rw.rst_pc[rd_addr[p].pt.tidx]);
                        KIND_PC_EN    : rd_next[p] = CR_DATA_W'(rw.en_pc[rd_addr[p].pt.tidx]);
                        KIND_STK_OFST : rd_next[p] = rw.stk_ofst[rd_addr[p].pt.tidx];
                        KIND_TLS_OFST : rd_next[p] = rw.tls_ofst[rd_addr[p].pt.tidx];
                        KIND_PC       : rd_next[p] = ro.pc[rd_addr[p].pt.tidx];
                        default       : rd_next[p] = '0;
                    endcase
                end else begin
                    case (rd_addr[p].raw)
                        CR_WHO_AM_I           : rd_next[p] =
                                                CR_DATA_W'({ro.core_id, ro.thread_id});
                        CR_THREAD_ID          : rd_next[p] = CR_DATA_W'(ro.thread_id);
                        CR_CORE_ID            : rd_next[p] = CR_DATA_W'(ro.core_id);
                        CR_STACK_BASE_OFFSET  : rd_next[p] = ro.cur_stk_ofst;
                        CR_TLS_BASE_OFFSET    : rd_next[p] = ro.cur_tls_ofst;
                        CR_SHARED_BASE_OFFSET : rd_next[p] = rw.shrd_ofst;
                        default : begin
                            if (rd_addr[p].raw[CR_ADDR_W-1:SCRATCH_IDX_W] ==
                                CR_SCRATCHPAD_BASE[CR_ADDR_W-1:SCRATCH_IDX_W]) begin
                                rd_next[p] = rw.scratch[rd_addr[p].raw[SCRATCH_IDX_W-1:0]];
                            end
                        end
                    endcase
                end
            end
        end
    end

    // ==================================================
    // Synchronous read, data held the next cycle
    // ==================================================
    always_ff @(posedge qclk or negedge rst_n) begin
        if (!rst_n) begin
            core_rd_data <= '0;
            ring_rd_data <= '0;
        end else begin
            core_rd_data <= rd_next[PORT_CORE];
            ring_rd_data <= rd_next[PORT_RING];
        end
    end

endmodule

`default_nettype wire

//--- logic/cr_mem.sv
`timescale 1ns/1ps
`default_nettype none

module cr_mem
    import cr_pkg::*;
(
    input  logic                   qclk,
    input  logic                   rst_n,
    input  logic                   all_pc_reset,   // Forces every PC reset output
    input  logic [CORE_ID_W-1:0]   core_id,
    input  logic [NUM_THREADS-1:0] thread,         // One-hot
    input  logic [CR_DATA_W-1:0]   pc,

    // Core access port
    input  logic [CR_ADDR_W-1:0]   core_addr,
    input  logic [CR_DATA_W-1:0]   core_wr_data,
    input  logic                   core_wr_en,
    input  logic                   core_rd_en,
    output logic [CR_DATA_W-1:0]   core_rd_data,

    // Ring access port
    input  logic [CR_ADDR_W-1:0]   ring_addr,
    input  logic [CR_DATA_W-1:0]   ring_wr_data,
    input  logic                   ring_wr_en,
    input  logic                   ring_rd_en,
    output logic [CR_DATA_W-1:0]   ring_rd_data,

    output logic [NUM_THREADS-1:0] pc_rst,
    output logic [NUM_THREADS-1:0] pc_en
);

    cr_access_if core_port ();
    cr_access_if ring_port ();
    cr_rw_if     cr_rw ();
    cr_ro_if     cr_ro ();

    // ==================================================
    // Plain ports into the access interfaces
    // ==================================================
    assign core_port.addr    = core_addr;
    assign core_port.wr_data = core_wr_data;
    assign core_port.wr_en   = core_wr_en;
    assign core_port.rd_en   = core_rd_en;

    assign ring_port.addr    = ring_addr;
    assign ring_port.wr_data = ring_wr_data;
    assign ring_port.wr_en   = ring_wr_en;
    assign ring_port.rd_en   = ring_rd_en;

    cr_rw_regs u_rw_regs (
        .qclk      (qclk),
        .rst_n     (rst_n),
        .core_port (core_port),
        .ring_port (ring_port),
        .rw        (cr_rw)
    );

    cr_thread_sampler u_thread_sampler (
        .qclk    (qclk),
        .rst_n   (rst_n),
        .thread  (thread),
        .pc      (pc),
        .core_id (core_id),
        .rw      (cr_rw),
        .ro      (cr_ro)
    );

    cr_read_mux u_read_mux (
        .qclk         (qclk),
        .rst_n        (rst_n),
        .core_port    (core_port),
        .ring_port    (ring_port),
        .rw           (cr_rw),
        .ro           (cr_ro),
        .core_rd_data (core_rd_data),
        .ring_rd_data (ring_rd_data)
    );

    // PC controls out to the core
    assign pc_rst = cr_rw.rst_pc | {NUM_THREADS{all_pc_reset}};
    assign pc_en  = cr_rw.en_pc;

endmodule

`default_nettype wire

//--- tests/cr_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cr_mem_tb
    import cr_pkg::*;
();

    localparam int WAIT_LIMIT = 8;                 // Cycles allowed for a PC output change

    logic                   qclk;
    logic                   rst_n;
    logic                   all_pc_reset;
    logic [CORE_ID_W-1:0]   core_id;
    logic [NUM_THREADS-1:0] thread;
    logic [CR_DATA_W-1:0]   pc;
    logic [CR_ADDR_W-1:0]   core_addr;
    logic [CR_DATA_W-1:0]   core_wr_data;
    logic                   core_wr_en;
    logic                   core_rd_en;
    logic [CR_DATA_W-1:0]   core_rd_data;
    logic [CR_ADDR_W-1:0]   ring_addr;
    logic [CR_DATA_W-1:0]   ring_wr_data;
    logic                   ring_wr_en;
    logic                   ring_rd_en;
    logic [CR_DATA_W-1:0]   ring_rd_data;
    logic [NUM_THREADS-1:0] pc_rst;
    logic [NUM_THREADS-1:0] pc_en;

    int mismatch_count = 0;
    int timeout_count  = 0;
    bit step_threads   = 1'b0;

    // Reference model state
    logic [NUM_THREADS-1:0] m_rst_pc;
    logic [NUM_THREADS-1:0] m_en_pc;
    logic [CR_DATA_W-1:0]   m_stk [NUM_THREADS];
    logic [CR_DATA_W-1:0]   m_tls [NUM_THREADS];
    logic [CR_DATA_W-1:0]   m_scratch [NUM_SCRATCH];
    logic [CR_DATA_W-1:0]   m_shrd;
    logic [CR_DATA_W-1:0]   m_pc [NUM_THREADS];
    logic [CR_DATA_W-1:0]   m_cur_stk;
    logic [CR_DATA_W-1:0]   m_cur_tls;
    logic [THREAD_IDX_W-1:0] m_tid;
    logic [CORE_ID_W-1:0]   m_core_id;
    logic [CR_DATA_W-1:0]   exp_core_rd;
    logic [CR_DATA_W-1:0]   exp_ring_rd;

    cr_mem u_dut (
        .qclk         (qclk),
        .rst_n        (rst_n),
        .all_pc_reset (all_pc_reset),
        .core_id      (core_id),
        .thread       (thread),
        .pc           (pc),
        .core_addr    (core_addr),
        .core_wr_data (core_wr_data),
        .core_wr_en   (core_wr_en),
        .core_rd_en   (core_rd_en),
        .core_rd_data (core_rd_data),
        .ring_addr    (ring_addr),
        .ring_wr_data (ring_wr_data),
        .ring_wr_en   (ring_wr_en),
        .ring_rd_en   (ring_rd_en),
        .ring_rd_data (ring_rd_data),
        .pc_rst       (pc_rst),
        .pc_en        (pc_en)
    );

    always #10 qclk = ~qclk;

    function automatic logic [CR_ADDR_W-1:0] pt_addr(input logic [CR_KIND_W-1:0] kind,
                                                     input logic [THREAD_IDX_W-1:0] tid);
        return {PER_THREAD_TAG, kind, tid};
    endfunction

    // One-hot bit p stands for thread p+1 one stage later, so the earlier thread is p+1 mod 4
    function automatic int derived_index(input logic [NUM_THREADS-1:0] onehot);
        int idx;
        idx = 0;
        for (int p = 0; p < NUM_THREADS; p++) begin
            if (onehot[p]) idx = (p + 1) % NUM_THREADS;
        end
        return idx;
    endfunction

    function automatic logic [CR_DATA_W-1:0] model_read(input logic [CR_ADDR_W-1:0] addr);
        logic [CR_KIND_W-1:0]    kind;
        logic [THREAD_IDX_W-1:0] tid;
        logic [CR_DATA_W-1:0]    val;
        kind = CR_KIND_W'(addr >> THREAD_IDX_W);
        tid  = THREAD_IDX_W'(addr);
        val  = '0;
        if ((addr >> (CR_KIND_W + THREAD_IDX_W)) == CR_ADDR_W'(PER_THREAD_TAG)) begin
            case (kind)
                KIND_PC_RST   : val = CR_DATA_W'(m_rst_pc[tid]);
                KIND_PC_EN    : val = CR_DATA_W'(m_en_pc[tid]);
                KIND_STK_OFST : val = m_stk[tid];
                KIND_TLS_OFST : val = m_tls[tid];
                KIND_PC       : val = m_pc[tid];
                default       : val = '0;
            endcase
        end else if (addr == CR_WHO_AM_I) begin
            val = CR_DATA_W'(m_core_id) * NUM_THREADS + CR_DATA_W'(m_tid);
        end else if (addr == CR_THREAD_ID) begin
            val = CR_DATA_W'(m_tid);
        end else if (addr == CR_CORE_ID) begin
            val = CR_DATA_W'(m_core_id);
        end else if (addr == CR_STACK_BASE_OFFSET) begin
            val = m_cur_stk;
        end else if (addr == CR_TLS_BASE_OFFSET) begin
            val = m_cur_tls;
        end else if (addr == CR_SHARED_BASE_OFFSET) begin
            val = m_shrd;
        end else if (addr >= CR_SCRATCHPAD_BASE && addr < CR_SCRATCHPAD_BASE + NUM_SCRATCH) begin
            val = m_scratch[addr - CR_SCRATCHPAD_BASE];
        end
        return val;
    endfunction

    task model_write(input logic [CR_ADDR_W-1:0] addr, input logic [CR_DATA_W-1:0] data);
        logic [CR_KIND_W-1:0]    kind;
        logic [THREAD_IDX_W-1:0] tid;
        kind = CR_KIND_W'(addr >> THREAD_IDX_W);
        tid  = THREAD_IDX_W'(addr);
        if ((addr >> (CR_KIND_W + THREAD_IDX_W)) == CR_ADDR_W'(PER_THREAD_TAG)) begin
            case (kind)
                KIND_PC_RST   : m_rst_pc[tid] <= data[0];
                KIND_PC_EN    : m_en_pc[tid]  <= data[0];
                KIND_STK_OFST : m_stk[tid]    <= data;
                KIND_TLS_OFST : m_tls[tid]    <= data;
                default       : ;                      // PC is read only
            endcase
        end else if (addr == CR_SHARED_BASE_OFFSET) begin
            m_shrd <= data;
        end else if (addr >= CR_SCRATCHPAD_BASE && addr < CR_SCRATCHPAD_BASE + NUM_SCRATCH) begin
            m_scratch[addr - CR_SCRATCHPAD_BASE] <= data;
        end
    endtask

    // ==================================================
    // Reference model
    // ==================================================
    always @(posedge qclk or negedge rst_n) begin
        if (!rst_n) begin
            m_rst_pc    <= '0;
            m_en_pc     <= '1;
            m_shrd      <= SHARED_OFFSET_RST;
            m_tid       <= '0;
            m_cur_stk   <= '0;
            m_cur_tls   <= '0;
            m_core_id   <= '0;
            exp_core_rd <= '0;
            exp_ring_rd <= '0;
            for (int t = 0; t < NUM_THREADS; t++) begin
                m_stk[t]     <= STK_OFFSET_RST[t];
                m_tls[t]     <= STK_OFFSET_RST[t];
                m_pc[t]      <= '0;
                m_scratch[t] <= '0;
            end
        end else begin
            exp_core_rd <= model_read(core_addr);
            exp_ring_rd <= model_read(ring_addr);
            if (core_wr_en) model_write(core_addr, core_wr_data);
            if (ring_wr_en) model_write(ring_addr, ring_wr_data);   // Issued last, so ring wins
            m_tid     <= THREAD_IDX_W'(derived_index(thread));
            m_cur_stk <= m_stk[derived_index(thread)];
            m_cur_tls <= m_tls[derived_index(thread)];
            m_pc[derived_index(thread)] <= pc;
            m_core_id <= core_id;
        end
    end

    task report_mismatch(input string what);
        mismatch_count++;
        $display("mismatch at %0t: %s", $time, what);
    endtask

    // ==================================================
    // Checks
    // ==================================================
    assert property (@(posedge qclk) disable iff (!rst_n)
                     core_rd_en |=> core_rd_data == exp_core_rd)
        else report_mismatch("core port read data differs from the model");
    assert property (@(posedge qclk) disable iff (!rst_n)
                     ring_rd_en |=> ring_rd_data == exp_ring_rd)
        else report_mismatch("ring port read data differs from the model");
    assert property (@(posedge qclk) disable iff (!rst_n)
                     !core_rd_en |=> core_rd_data == '0)
        else report_mismatch("core port read data not zero without a read");
    assert property (@(posedge qclk) disable iff (!rst_n)
                     !ring_rd_en |=> ring_rd_data == '0)
        else report_mismatch("ring port read data not zero without a read");
    assert property (@(posedge qclk) disable iff (!rst_n)
                     pc_rst == (m_rst_pc | {NUM_THREADS{all_pc_reset}}))
        else report_mismatch("pc_rst differs from the model");
    assert property (@(posedge qclk) disable iff (!rst_n) pc_en == m_en_pc)
        else report_mismatch("pc_en differs from the model");

    task finish_run();
        $display("Run done: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    // One cycle of port activity
    task drive_ports(input logic cw, input logic cr, input logic [CR_ADDR_W-1:0] ca,
                     input logic [CR_DATA_W-1:0] cd, input logic rw, input logic rr,
                     input logic [CR_ADDR_W-1:0] ra, input logic [CR_DATA_W-1:0] rd);
        @(posedge qclk);
        core_wr_en   <= cw;
        core_rd_en   <= cr;
        core_addr    <= ca;
        core_wr_data <= cd;
        ring_wr_en   <= rw;
        ring_rd_en   <= rr;
        ring_addr    <= ra;
        ring_wr_data <= rd;
        if (step_threads) begin
            thread <= {thread[NUM_THREADS-2:0], thread[NUM_THREADS-1]};
            pc     <= $urandom;
        end
    endtask

    task write_core(input logic [CR_ADDR_W-1:0] a, input logic [CR_DATA_W-1:0] d);
        drive_ports(1'b1, 1'b0, a, d, 1'b0, 1'b0, '0, '0);
    endtask

    task write_ring(input logic [CR_ADDR_W-1:0] a, input logic [CR_DATA_W-1:0] d);
        drive_ports(1'b0, 1'b0, '0, '0, 1'b1, 1'b0, a, d);
    endtask

    task read_ports(input logic [CR_ADDR_W-1:0] ca, input logic [CR_ADDR_W-1:0] ra);
        drive_ports(1'b0, 1'b1, ca, '0, 1'b0, 1'b1, ra, '0);
    endtask

    task wait_pc_outputs(input logic [NUM_THREADS-1:0] exp_rst,
                         input logic [NUM_THREADS-1:0] exp_en);
        int  cycles;
        bit  seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            drive_ports(1'b0, 1'b0, '0, '0, 1'b0, 1'b0, '0, '0);
            @(negedge qclk);                           // Outputs settled mid cycle
            seen = (pc_rst == exp_rst) && (pc_en == exp_en);
            cycles++;
        end
        if (!seen) begin
            timeout_count++;
            $display("timeout: pc_rst and pc_en did not reach the expected values by %0t", $time);
            finish_run();
        end
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin
        void'($urandom(32));
        qclk         = 1'b0;
        rst_n        = 1'b0;
        all_pc_reset = 1'b0;
        core_id      = 8'h5a;
        thread       = 4'b0001;
        pc           = '0;
        core_addr    = '0;
        core_wr_data = '0;
        core_wr_en   = 1'b0;
        core_rd_en   = 1'b0;
        ring_addr    = '0;
        ring_wr_data = '0;
        ring_wr_en   = 1'b0;
        ring_rd_en   = 1'b0;
        repeat (2) @(posedge qclk);
        rst_n <= 1'b1;
        wait_pc_outputs('0, '1);

        // Reset values
        read_ports(CR_SHARED_BASE_OFFSET, CR_STACK_BASE_OFFSET);
        for (int t = 0; t < NUM_THREADS; t++) begin
            read_ports(pt_addr(KIND_STK_OFST, t), pt_addr(KIND_TLS_OFST, t));
            read_ports(pt_addr(KIND_PC_RST, t), pt_addr(KIND_PC_EN, t));
            read_ports(CR_ADDR_W'(CR_SCRATCHPAD_BASE + t), CR_TLS_BASE_OFFSET);
        end

        // Write through either port, read back through both
        for (int s = 0; s < NUM_SCRATCH; s++) begin
            if (s % 2 == 0) write_core(CR_ADDR_W'(CR_SCRATCHPAD_BASE + s), $urandom);
            else write_ring(CR_ADDR_W'(CR_SCRATCHPAD_BASE + s), $urandom);
        end
        write_ring(CR_SHARED_BASE_OFFSET, $urandom);
        for (int t = 0; t < NUM_THREADS; t++) begin
            write_core(pt_addr(KIND_STK_OFST, t), $urandom);
            write_ring(pt_addr(KIND_TLS_OFST, t), $urandom);
        end
        for (int s = 0; s < NUM_SCRATCH; s++) begin
            read_ports(CR_ADDR_W'(CR_SCRATCHPAD_BASE + s), CR_ADDR_W'(CR_SCRATCHPAD_BASE + s));
            read_ports(pt_addr(KIND_STK_OFST, s), pt_addr(KIND_TLS_OFST, s));
        end
        read_ports(CR_SHARED_BASE_OFFSET, CR_SHARED_BASE_OFFSET);

        // PC controls and the global reset override
        write_core(pt_addr(KIND_PC_RST, 1), 32'd1);
        wait_pc_outputs(4'b0010, 4'b1111);
        write_ring(pt_addr(KIND_PC_EN, 2), 32'd0);
        wait_pc_outputs(4'b0010, 4'b1011);
        read_ports(pt_addr(KIND_PC_RST, 1), pt_addr(KIND_PC_EN, 2));
        @(posedge qclk);
        all_pc_reset <= 1'b1;
        wait_pc_outputs(4'b1111, 4'b1011);
        @(posedge qclk);
        all_pc_reset <= 1'b0;
        write_core(pt_addr(KIND_PC_RST, 1), 32'd0);
        write_core(pt_addr(KIND_PC_EN, 2), 32'd1);
        wait_pc_outputs(4'b0000, 4'b1111);

        // Collisions, unused addresses and idle reads
        drive_ports(1'b1, 1'b0, CR_SCRATCHPAD_BASE, $urandom,
                    1'b1, 1'b0, CR_SCRATCHPAD_BASE, $urandom);
        drive_ports(1'b1, 1'b0, pt_addr(KIND_STK_OFST, 3), $urandom,
                    1'b1, 1'b0, pt_addr(KIND_STK_OFST, 3), $urandom);
        write_ring(pt_addr(KIND_PC, 0), $urandom);     // Ignored by the block
        read_ports(CR_SCRATCHPAD_BASE, pt_addr(KIND_STK_OFST, 3));
        read_ports(8'h40, pt_addr(3'd5, 0));
        read_ports(pt_addr(3'd7, 3), pt_addr(KIND_PC, 0));
        drive_ports(1'b0, 1'b0, CR_SHARED_BASE_OFFSET, '0, 1'b0, 1'b0, CR_SCRATCHPAD_BASE, '0);

        // Thread rotation with random PCs
        step_threads = 1'b1;
        for (int i = 0; i < 30; i++) begin
            case (i % 5)
                0       : read_ports(CR_THREAD_ID, pt_addr(KIND_PC, i % NUM_THREADS));
                1       : read_ports(CR_WHO_AM_I, pt_addr(KIND_PC, i % NUM_THREADS));
                2       : read_ports(CR_STACK_BASE_OFFSET, pt_addr(KIND_PC, i % NUM_THREADS));
                3       : read_ports(CR_TLS_BASE_OFFSET, CR_THREAD_ID);
                default : read_ports(CR_CORE_ID, CR_WHO_AM_I);
            endcase
        end
        step_threads = 1'b0;
        repeat (3) drive_ports(1'b0, 1'b0, '0, '0, 1'b0, 1'b0, '0, '0);
        finish_run();
    end

endmodule

`default_nettype wire

//--- cr_mem.f
logic/cr_pkg.sv
logic/cr_access_if.sv
logic/cr_rw_if.sv
logic/cr_ro_if.sv
logic/cr_rw_regs.sv
logic/cr_thread_sampler.sv
logic/cr_read_mux.sv
logic/cr_mem.sv
tests/cr_mem_tb.sv
